/* instruction_id_unit.f */
source/id_pkg.sv
source/id_allocator.sv
source/metadata_store.sv
source/id_inuse_tracker.sv
source/retire_selector.sv
source/instruction_id_unit.sv
tests/instruction_id_unit_tb.sv

/* tests/instruction_id_unit_tb.sv */
/*
 * Directed testbench for the instruction-ID unit, with a reference
 * model of IDs, PCs, instructions and phys registers
 */
`timescale 1ns/1ns
`default_nettype none

module instruction_id_unit_tb;
    import id_pkg::*;

    // Whole sequence runs in under 200 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    // Reference record for one ID
    typedef struct packed {
        id_t id;
        logic [31:0] pc;
        logic [31:0] instruction;
        fetch_metadata_t fetch_metadata;
        phys_addr_t phys_addr;
        logic writes_rd;
    } instr_rec_t;

    logic clk;
    logic rst;
    logic gc_fetch_flush;
    id_t pc_id;
    logic pc_id_available;
    logic [31:0] if_pc;
    logic pc_id_assigned;
    id_t fetch_id;
    logic early_branch_flush;
    logic fetch_complete;
    logic [31:0] fetch_instruction;
    fetch_metadata_t fetch_metadata;
    decode_packet_t decode;
    logic decode_advance;
    logic decode_uses_rd;
    logic [4:0] decode_rd_addr;
    phys_addr_t decode_phys_rd_addr;
    issue_packet_t issue;
    logic instruction_issued;
    logic instruction_issued_with_rd;
    wb_packet_t wb_packet [NUM_WB_GROUPS];
    commit_packet_t commit_packet [NUM_WB_GROUPS];
    retire_packet_t retire;
    id_t retire_ids [RETIRE_PORTS];
    logic [RETIRE_PORTS-1:0] retire_port_valid;
    count_t post_issue_count;
    id_t exception_id;
    logic [31:0] exception_pc;

    // Fetched IDs waiting for decode, and the latest record per ID
    instr_rec_t decode_q [$];
    instr_rec_t by_id [MAX_IDS];
    id_t next_id = '0;
    int cycles = 0;
    int checks = 0;
    int errors = 0;

    instruction_id_unit uut (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: DUT did not reach the expected state in %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Compare tasks

    task automatic report_mismatch(string what, string expected, string actual);
        errors++;
        $display("Fail at %0t ns: %s expected %s, got %s", $time, what, expected, actual);
    endtask

    // Payload only matters when valid is expected
    task automatic check_decode(string what, decode_packet_t actual, decode_packet_t expected);
        checks++;
        if (actual.valid !== expected.valid || (expected.valid && actual !== expected)) begin
            report_mismatch(what, $sformatf("%h", expected), $sformatf("%h", actual));
        end
    endtask

    task automatic check_commit(string what, commit_packet_t actual, commit_packet_t expected);
        checks++;
        if (actual.valid !== expected.valid || (expected.valid && actual !== expected)) begin
            report_mismatch(what, $sformatf("%h", expected), $sformatf("%h", actual));
        end
    endtask

    // phys_id only names a register when valid
    task automatic check_retire(string what, retire_packet_t actual, retire_packet_t expected);
        checks++;
        if (actual.valid !== expected.valid || actual.count !== expected.count
                || (expected.valid && actual.phys_id !== expected.phys_id)) begin
            report_mismatch(what, $sformatf("%h", expected), $sformatf("%h", actual));
        end
    endtask

    task automatic check_id(string what, id_t actual, id_t expected);
        checks++;
        if (actual !== expected) begin
            report_mismatch(what, $sformatf("%0d", expected), $sformatf("%0d", actual));
        end
    endtask

    task automatic check_count(string what, count_t actual, count_t expected);
        checks++;
        if (actual !== expected) begin
            report_mismatch(what, $sformatf("%0d", expected), $sformatf("%0d", actual));
        end
    endtask

    task automatic check_flag(string what, logic actual, logic expected);
        checks++;
        if (actual !== expected) begin
            report_mismatch(what, $sformatf("%b", expected), $sformatf("%b", actual));
        end
    endtask

    task automatic check_word(string what, logic [31:0] actual, logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            report_mismatch(what, $sformatf("%h", expected), $sformatf("%h", actual));
        end
    endtask

    function automatic retire_packet_t make_retire(logic valid, id_t phys_id,
            retire_count_t count);
        retire_packet_t packet;
        packet.valid = valid;
        packet.phys_id = phys_id;
        packet.count = count;
        return packet;
    endfunction

    //////////////////////////////////////////////////
    // Drivers

    // Rising edge, strobes back to idle
    task automatic next_cycle();
        @(posedge clk);
        pc_id_assigned <= 1'b0;
        fetch_complete <= 1'b0;
        decode_advance <= 1'b0;
        instruction_issued <= 1'b0;
        instruction_issued_with_rd <= 1'b0;
        issue <= '0;
        wb_packet[0] <= '0;
        wb_packet[1] <= '0;
        gc_fetch_flush <= 1'b0;
        early_branch_flush <= 1'b0;
    endtask

    // Mid-cycle, outputs settled
    task automatic sample_point();
        @(negedge clk);
    endtask

    // PC assigned and fetch completed in one cycle
    task automatic fetch_instr(logic [31:0] pc, fetch_metadata_t meta);
        instr_rec_t rec;
        rec = '0;
        rec.id = next_id;
        rec.pc = pc;
        rec.instruction = $urandom;
        rec.fetch_metadata = meta;
        sample_point();
        check_id("pc_id", pc_id, next_id);
        check_id("fetch_id", fetch_id, next_id);
        next_cycle();
        pc_id_assigned <= 1'b1;
        if_pc <= pc;
        fetch_complete <= 1'b1;
        fetch_instruction <= rec.instruction;
        fetch_metadata <= meta;
        next_cycle();
        decode_q.push_back(rec);
        by_id[rec.id] = rec;
        next_id++;
    endtask

    // Checks the oldest fetched ID, then advances it with its rd
    task automatic decode_instr(logic uses_rd, logic [4:0] rd, phys_addr_t phys);
        instr_rec_t rec;
        decode_packet_t expected;
        rec = decode_q.pop_front();
        expected = '{valid: 1'b1, id: rec.id, pc: rec.pc, instruction: rec.instruction,
            fetch_metadata: rec.fetch_metadata};
        sample_point();
        check_decode("decode packet", decode, expected);
        next_cycle();
        decode_advance <= 1'b1;
        decode_uses_rd <= uses_rd;
        decode_rd_addr <= rd;
        decode_phys_rd_addr <= phys;
        next_cycle();
        // x0 is no destination
        rec.phys_addr = phys;
        rec.writes_rd = uses_rd && rd != 5'd0;
        by_id[rec.id] = rec;
    endtask

    // Group 0 writes back in the issue cycle when with_wb0 is set
    task automatic issue_instr(id_t id, logic multicycle, logic with_wb0, logic [31:0] data);
        commit_packet_t expected;
        expected = '{valid: 1'b1, id: id, phys_addr: by_id[id].phys_addr, data: data};
        next_cycle();
        instruction_issued <= 1'b1;
        instruction_issued_with_rd <= by_id[id].writes_rd;
        issue <= '{stage_valid: 1'b1, id: id, phys_rd_addr: by_id[id].phys_addr,
            is_multicycle: multicycle};
        if (with_wb0) begin
            wb_packet[0] <= '{valid: 1'b1, id: id, data: data};
            sample_point();
            check_commit("group 0 commit", commit_packet[0], expected);
        end
        next_cycle();
    endtask

    task automatic writeback_group1(id_t id, logic [31:0] data);
        commit_packet_t expected;
        expected = '{valid: by_id[id].phys_addr != '0, id: id,
            phys_addr: by_id[id].phys_addr, data: data};
        next_cycle();
        wb_packet[1] <= '{valid: 1'b1, id: id, data: data};
        sample_point();
        check_commit("group 1 commit", commit_packet[1], expected);
        next_cycle();
    endtask

    task automatic wait_for_available(logic level);
        sample_point();
        while (pc_id_available !== level) begin
            next_cycle();
            sample_point();
        end
    endtask

    //////////////////////////////////////////////////
    // Tests

    task automatic reset_values();
        sample_point();
        check_flag("pc_id_available after reset", pc_id_available, 1'b1);
        check_flag("decode.valid after reset", decode.valid, 1'b0);
        check_retire("retire after reset", retire, make_retire(1'b0, '0, '0));
        check_flag("retire_port_valid[0] after reset", retire_port_valid[0], 1'b0);
        check_flag("retire_port_valid[1] after reset", retire_port_valid[1], 1'b0);
        check_count("post_issue_count after reset", post_issue_count, '0);
        check_id("retire_ids[0] after reset", retire_ids[0], id_t'(0));
        check_id("retire_ids[1] after reset", retire_ids[1], id_t'(1));
    endtask

    // IDs 0 to 4, decode info reused by the retire tests
    task automatic fetch_to_decode();
        for (int k = 0; k < 5; k++) begin
            fetch_instr(32'h0000_1000 + 32'(4 * k), '{valid_addr: 1'b1, access_fault: k == 3});
        end
        decode_instr(1'b1, 5'd5, 6'd10);
        decode_instr(1'b1, 5'd3, 6'd11);
        decode_instr(1'b1, 5'd0, 6'd12);
        decode_instr(1'b1, 5'd7, 6'd13);
        decode_instr(1'b1, 5'd8, 6'd14);
        sample_point();
        check_flag("decode.valid after last advance", decode.valid, 1'b0);
    endtask

    task automatic pool_exhaustion();
        for (int k = 5; k < MAX_IDS; k++) begin
            fetch_instr(32'h0000_2000 + 32'(4 * k), '{valid_addr: 1'b1, access_fault: 1'b0});
        end
        wait_for_available(1'b0);
        issue_instr(id_t'(0), 1'b0, 1'b0, '0);
        sample_point();
        check_retire("retire of ID 0", retire, make_retire(by_id[0].writes_rd, id_t'(0), 2'd1));
        wait_for_available(1'b1);
    endtask

    task automatic in_order_retire();
        logic [31:0] data;
        data = $urandom;
        issue_instr(id_t'(1), 1'b0, 1'b1, data);
        sample_point();
        check_retire("retire of ID 1", retire, make_retire(by_id[1].writes_rd, id_t'(1), 2'd1));
        // ID 2 has rd x0
        issue_instr(id_t'(2), 1'b0, 1'b0, '0);
        sample_point();
        check_retire("retire of ID 2", retire, make_retire(by_id[2].writes_rd, id_t'(2), 2'd1));
        // Writeback with no destination register
        next_cycle();
        wb_packet[0] <= '{valid: 1'b1, id: id_t'(2), data: data};
        sample_point();
        check_commit("commit to phys 0", commit_packet[0], '0);
        next_cycle();
        sample_point();
        check_count("post_issue_count after retire", post_issue_count, '0);
    endtask

    // ID 3 multicycle holds back 4 to 7, which then retire in pairs
    task automatic multicycle_block();
        logic [31:0] data;
        decode_instr(1'b0, 5'd9, 6'd0);
        decode_instr(1'b1, 5'd0, 6'd16);
        decode_instr(1'b1, 5'd12, 6'd17);
        issue_instr(id_t'(3), 1'b1, 1'b0, '0);
        for (int k = 4; k < MAX_IDS; k++) begin
            issue_instr(id_t'(k), 1'b0, 1'b0, '0);
            sample_point();
            check_retire("retire behind ID 3", retire, make_retire(1'b0, '0, '0));
        end
        check_count("post_issue_count while blocked", post_issue_count, count_t'(5));
        check_id("retire_ids[0] while blocked", retire_ids[0], id_t'(3));
        data = $urandom;
        writeback_group1(id_t'(3), data);
        sample_point();
        // Both write rd, so only one goes
        check_retire("retire of ID 3", retire, make_retire(1'b1, id_t'(3), 2'd1));
        check_flag("retire_port_valid[1] with two writers", retire_port_valid[1], 1'b0);
        next_cycle();
        sample_point();
        check_retire("retire of IDs 4 and 5", retire, make_retire(1'b1, id_t'(4), 2'd2));
        next_cycle();
        sample_point();
        check_retire("retire of IDs 6 and 7", retire, make_retire(1'b1, id_t'(7), 2'd2));
        next_cycle();
        sample_point();
        check_count("post_issue_count after drain", post_issue_count, '0);
    endtask

    // ID 0 waits in issue when the flush hits
    task automatic flush_and_exception();
        for (int k = 0; k < 3; k++) begin
            fetch_instr(32'h0000_3000 + 32'(4 * k), '{valid_addr: 1'b1, access_fault: 1'b0});
        end
        decode_instr(1'b1, 5'd1, 6'd20);
        next_cycle();
        gc_fetch_flush <= 1'b1;
        issue <= '{stage_valid: 1'b1, id: id_t'(0), phys_rd_addr: 6'd20, is_multicycle: 1'b0};
        next_cycle();
        decode_q.delete();
        next_id = '0;
        sample_point();
        check_flag("decode.valid after flush", decode.valid, 1'b0);
        check_id("pc_id after flush", pc_id, id_t'(0));
        check_id("fetch_id after flush", fetch_id, id_t'(0));
        check_flag("pc_id_available after flush", pc_id_available, 1'b1);
        next_cycle();
        exception_id <= id_t'(2);
        sample_point();
        check_word("exception_pc of ID 2", exception_pc, by_id[2].pc);
        next_cycle();
        exception_id <= id_t'(5);
        sample_point();
        check_word("exception_pc of ID 5", exception_pc, by_id[5].pc);
    endtask

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        void'($urandom(32'hb322_311f));
        rst <= 1'b1;
        gc_fetch_flush <= 1'b0;
        if_pc <= '0;
        pc_id_assigned <= 1'b0;
        early_branch_flush <= 1'b0;
        fetch_complete <= 1'b0;
        fetch_instruction <= '0;
        fetch_metadata <= '0;
        decode_advance <= 1'b0;
        decode_uses_rd <= 1'b0;
        decode_rd_addr <= '0;
        decode_phys_rd_addr <= '0;
        issue <= '0;
        instruction_issued <= 1'b0;
        instruction_issued_with_rd <= 1'b0;
        wb_packet[0] <= '0;
        wb_packet[1] <= '0;
        exception_id <= '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        next_cycle();

        reset_values();
        fetch_to_decode();
        pool_exhaustion();
        in_order_retire();
        multicycle_block();
        flush_and_exception();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/instruction_id_unit.sv */
/*
 * Instruction-ID unit top level: allocator, metadata store,
 * in-use tracker and retire selector
 */
`timescale 1ns/1ns
`default_nettype none

module instruction_id_unit (
    input wire logic clk,
    input wire logic rst,
    input wire logic gc_fetch_flush,

    // Fetch
    output id_pkg::id_t pc_id,
    output logic pc_id_available,
    input wire logic [31:0] if_pc,
    input wire logic pc_id_assigned,
    output id_pkg::id_t fetch_id,
    input wire logic early_branch_flush,
    input wire logic fetch_complete,
    input wire logic [31:0] fetch_instruction,
    input wire id_pkg::fetch_metadata_t fetch_metadata,

    // Decode and renamer
    output id_pkg::decode_packet_t decode,
    input wire logic decode_advance,
    input wire logic decode_uses_rd,
    input wire logic [4:0] decode_rd_addr,
    input wire id_pkg::phys_addr_t decode_phys_rd_addr,

    // Issue
    input wire id_pkg::issue_packet_t issue,
    input wire logic instruction_issued,
    input wire logic instruction_issued_with_rd,

    // Writeback and commit
    input wire id_pkg::wb_packet_t wb_packet [id_pkg::NUM_WB_GROUPS],
    output id_pkg::commit_packet_t commit_packet [id_pkg::NUM_WB_GROUPS],

    // Retire
    output id_pkg::retire_packet_t retire,
    output id_pkg::id_t retire_ids [id_pkg::RETIRE_PORTS],
    output logic [id_pkg::RETIRE_PORTS-1:0] retire_port_valid,
    output id_pkg::count_t post_issue_count,

    // Exception
    input wire id_pkg::id_t exception_id,
    output logic [31:0] exception_pc
);
    import id_pkg::*;

    id_t decode_id;
    logic decode_valid;
    decode_fields_t decode_fields;
    logic [RETIRE_PORTS-1:0] retire_uses_rd;
    logic [RETIRE_PORTS-1:0] retire_in_use;

    // Tracker port 0 marks issue, port 1 marks group-1 writeback
    logic [1:0] inuse_toggle;
    id_t inuse_toggle_ids [2];

    //////////////////////////////////////////////////
    // ID pointers and counts

    id_allocator allocator (
        .clk                (clk),
        .rst                (rst),
        .gc_fetch_flush     (gc_fetch_flush),
        .early_branch_flush (early_branch_flush),
        .pc_id_assigned     (pc_id_assigned),
        .fetch_complete     (fetch_complete),
        .decode_advance     (decode_advance),
        .instruction_issued (instruction_issued),
        .issue              (issue),
        .retire_count       (retire.count),
        .pc_id              (pc_id),
        .fetch_id           (fetch_id),
        .decode_id          (decode_id),
        .decode_valid       (decode_valid),
        .pc_id_available    (pc_id_available),
        .post_issue_count   (post_issue_count)
    );

    //////////////////////////////////////////////////
    // Metadata tables

    metadata_store store (
        .clk                 (clk),
        .pc_id               (pc_id),
        .if_pc               (if_pc),
        .pc_id_assigned      (pc_id_assigned),
        .fetch_id            (fetch_id),
        .fetch_complete      (fetch_complete),
        .fetch_instruction   (fetch_instruction),
        .fetch_metadata      (fetch_metadata),
        .decode_id           (decode_id),
        .decode_advance      (decode_advance),
        .decode_uses_rd      (decode_uses_rd),
        .decode_rd_addr      (decode_rd_addr),
        .decode_phys_rd_addr (decode_phys_rd_addr),
        .issue_phys_rd_addr  (issue.phys_rd_addr),
        .wb_packet           (wb_packet),
        .retire_ids          (retire_ids),
        .exception_id        (exception_id),
        .decode_fields       (decode_fields),
        .commit_packet       (commit_packet),
        .retire_uses_rd      (retire_uses_rd),
        .exception_pc        (exception_pc)
    );

    //////////////////////////////////////////////////
    // Outstanding multicycle IDs

    // Only multicycle writers can still be busy after issue
    assign inuse_toggle[0] = instruction_issued_with_rd & issue.is_multicycle;
    assign inuse_toggle[1] = wb_packet[1].valid;
    assign inuse_toggle_ids[0] = issue.id;
    assign inuse_toggle_ids[1] = wb_packet[1].id;

    id_inuse_tracker tracker (
        .clk        (clk),
        .rst        (rst),
        .toggle     (inuse_toggle),
        .toggle_ids (inuse_toggle_ids),
        .read_ids   (retire_ids),
        .in_use     (retire_in_use)
    );

    //////////////////////////////////////////////////
    // Retire

    retire_selector selector (
        .clk               (clk),
        .rst               (rst),
        .post_issue_count  (post_issue_count),
        .uses_rd           (retire_uses_rd),
        .in_use            (retire_in_use),
        .retire            (retire),
        .retire_ids        (retire_ids),
        .retire_port_valid (retire_port_valid)
    );

    // Decode packet from allocator state and table reads
    assign decode.valid = decode_valid;
    assign decode.id = decode_id;
    assign decode.pc = decode_fields.pc;
    assign decode.instruction = decode_fields.instruction;
    assign decode.fetch_metadata = decode_fields.fetch_metadata;

endmodule

`default_nettype wire

/* source/retire_selector.sv */
/*
 * Retire ID registers and the in-order retire decision
 */
`timescale 1ns/1ns
`default_nettype none

module retire_selector (
    input wire logic clk,
    input wire logic rst,
    input wire id_pkg::count_t post_issue_count,
    input wire logic [id_pkg::RETIRE_PORTS-1:0] uses_rd,
    input wire logic [id_pkg::RETIRE_PORTS-1:0] in_use,
    output id_pkg::retire_packet_t retire,
    output id_pkg::id_t retire_ids [id_pkg::RETIRE_PORTS],
    output logic [id_pkg::RETIRE_PORTS-1:0] retire_port_valid
);
    import id_pkg::*;

    logic [RETIRE_PORTS-1:0] is_post_issue;
    logic [RETIRE_PORTS-1:0] ready;
    logic contiguous;
    logic writer_seen;

    // Port i holds the i-th oldest issued ID
    always_ff @(posedge clk) begin
        for (int i = 0; i < RETIRE_PORTS; i++) begin
            if (rst) begin
                retire_ids[i] <= id_t'(i);
            end else begin
                retire_ids[i] <= retire_ids[i] + id_t'(retire.count);
            end
        end
    end

    //////////////////////////////////////////////////
    // Retire decision

    // Retired block starts at port 0 with no gaps
    // and holds at most one register writer
    always_comb begin
        contiguous = 1'b1;
        writer_seen = 1'b0;
        retire.valid = 1'b0;
        retire.count = '0;
        retire.phys_id = retire_ids[0];
        for (int i = 0; i < RETIRE_PORTS; i++) begin
            is_post_issue[i] = post_issue_count > count_t'(i);
            ready[i] = is_post_issue[i] & contiguous & ~in_use[i];
            retire_port_valid[i] = ready[i] & (~uses_rd[i] | ~retire.valid);
            contiguous = contiguous & retire_port_valid[i];

            // First ready writer names the register
            if (ready[i] && uses_rd[i] && !writer_seen) begin
                retire.phys_id = retire_ids[i];
                writer_seen = 1'b1;
            end

            retire.valid = retire.valid | (retire_port_valid[i] & uses_rd[i]);
            retire.count = retire.count + retire_count_t'(retire_port_valid[i]);
        end
    end

endmodule

`default_nettype wire

/* source/id_inuse_tracker.sv */
/*
 * Toggle-bit tracker of multicycle IDs still outstanding
 */
`timescale 1ns/1ns
`default_nettype none

module id_inuse_tracker (
    input wire logic clk,
    input wire logic rst,
    input wire logic [1:0] toggle,
    input wire id_pkg::id_t toggle_ids [2],
    input wire id_pkg::id_t read_ids [id_pkg::RETIRE_PORTS],
    output logic [id_pkg::RETIRE_PORTS-1:0] in_use
);
    import id_pkg::*;

    // One bit array per write port
    logic [MAX_IDS-1:0] toggle_bits [2];

    // Each strobe flips the bit of its ID
    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (rst) begin
                toggle_bits[p] <= '0;
            end else if (toggle[p]) begin
                toggle_bits[p][toggle_ids[p]] <= ~toggle_bits[p][toggle_ids[p]];
            end
        end
    end

    // Set by one port, cleared by the other
    always_comb begin
        for (int r = 0; r < RETIRE_PORTS; r++) begin
            in_use[r] = toggle_bits[0][read_ids[r]] ^ toggle_bits[1][read_ids[r]];
        end
    end

    // Issue and group-1 writeback of one ID are never in the same cycle
    no_same_id_toggle: assert property (
        @(posedge clk) disable iff (rst)
        !(toggle[0] && toggle[1] && (toggle_ids[0] == toggle_ids[1]))
    ) else $error("Both ports toggled the same ID");

endmodule

`default_nettype wire

/* source/metadata_store.sv */
/*
 * Per-ID tables for PC, instruction, fetch status, phys rd and uses-rd,
 * with read ports for decode, commit, retire and exceptions
 */
`timescale 1ns/1ns
`default_nettype none

module metadata_store (
    input wire logic clk,
    input wire id_pkg::id_t pc_id,
    input wire logic [31:0] if_pc,
    input wire logic pc_id_assigned,
    input wire id_pkg::id_t fetch_id,
    input wire logic fetch_complete,
    input wire logic [31:0] fetch_instruction,
    input wire id_pkg::fetch_metadata_t fetch_metadata,
    input wire id_pkg::id_t decode_id,
    input wire logic decode_advance,
    input wire logic decode_uses_rd,
    input wire logic [4:0] decode_rd_addr,
    input wire id_pkg::phys_addr_t decode_phys_rd_addr,
    input wire id_pkg::phys_addr_t issue_phys_rd_addr,
    input wire id_pkg::wb_packet_t wb_packet [id_pkg::NUM_WB_GROUPS],
    input wire id_pkg::id_t retire_ids [id_pkg::RETIRE_PORTS],
    input wire id_pkg::id_t exception_id,
    output id_pkg::decode_fields_t decode_fields,
    output id_pkg::commit_packet_t commit_packet [id_pkg::NUM_WB_GROUPS],
    output logic [id_pkg::RETIRE_PORTS-1:0] retire_uses_rd,
    output logic [31:0] exception_pc
);
    import id_pkg::*;

    // Small tables, written at one point each and read asynchronously
    logic [31:0] pc_table [MAX_IDS];
    logic [31:0] instruction_table [MAX_IDS];
    fetch_metadata_t fetch_metadata_table [MAX_IDS];
    phys_addr_t phys_addr_table [MAX_IDS];
    logic uses_rd_table [MAX_IDS];

    phys_addr_t commit_phys_addr [NUM_WB_GROUPS];

    //////////////////////////////////////////////////
    // Table writes

    // PC written when the ID is handed out
    always_ff @(posedge clk) begin
        if (pc_id_assigned) begin
            pc_table[pc_id] <= if_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_complete) begin
            instruction_table[fetch_id] <= fetch_instruction;
            fetch_metadata_table[fetch_id] <= fetch_metadata;
        end
    end

    // A write to x0 is not a register write
    always_ff @(posedge clk) begin
        if (decode_advance) begin
            phys_addr_table[decode_id] <= decode_phys_rd_addr;
            uses_rd_table[decode_id] <= decode_uses_rd & (|decode_rd_addr);
        end
    end

    //////////////////////////////////////////////////
    // Reads

    assign decode_fields.pc = pc_table[decode_id];
    assign decode_fields.instruction = instruction_table[decode_id];
    assign decode_fields.fetch_metadata = fetch_metadata_table[decode_id];

    always_comb begin
        for (int i = 0; i < RETIRE_PORTS; i++) begin
            retire_uses_rd[i] = uses_rd_table[retire_ids[i]];
        end
    end

    assign exception_pc = pc_table[exception_id];

    // Group 0 writes back in the issue cycle, issue still holds its rd
    assign commit_phys_addr[0] = issue_phys_rd_addr;

    // Later groups look up rd by ID
    generate
        for (genvar g = 1; g < NUM_WB_GROUPS; g++) begin : g_table_addr
            assign commit_phys_addr[g] = phys_addr_table[wb_packet[g].id];
        end
    endgenerate

    generate
        for (genvar g = 0; g < NUM_WB_GROUPS; g++) begin : g_commit
            assign commit_packet[g].valid = wb_packet[g].valid & (|commit_phys_addr[g]);
            assign commit_packet[g].id = wb_packet[g].id;
            assign commit_packet[g].phys_addr = commit_phys_addr[g];
            assign commit_packet[g].data = wb_packet[g].data;
        end
    endgenerate

endmodule

`default_nettype wire

/* source/id_allocator.sv */
/*
 * ID pointers for fetch and decode, pre- and post-issue counts,
 * ID availability and the flush rewind
 */
`timescale 1ns/1ns
`default_nettype none

module id_allocator (
    input wire logic clk,
    input wire logic rst,
    input wire logic gc_fetch_flush,
    input wire logic early_branch_flush,
    input wire logic pc_id_assigned,
    input wire logic fetch_complete,
    input wire logic decode_advance,
    input wire logic instruction_issued,
    input wire id_pkg::issue_packet_t issue,
    input wire id_pkg::retire_count_t retire_count,
    output id_pkg::id_t pc_id,
    output id_pkg::id_t fetch_id,
    output id_pkg::id_t decode_id,
    output logic decode_valid,
    output logic pc_id_available,
    output id_pkg::count_t post_issue_count
);
    import id_pkg::*;

    count_t fetched_count;
    count_t pre_issue_count;
    count_t pre_issue_count_next;
    count_t post_issue_count_next;
    count_t inflight_count;

    id_t oldest_pre_issue_id;
    id_t pc_id_base;
    id_t fetch_id_base;
    id_t decode_id_base;

    //////////////////////////////////////////////////
    // Pointers

    // Oldest ID not yet issued, sits in issue or in decode
    assign oldest_pre_issue_id = issue.stage_valid ? issue.id : decode_id;

    // Flush rewinds, early branch only pulls pc back to fetch
    always_comb begin
        if (gc_fetch_flush) begin
            pc_id_base = oldest_pre_issue_id;
            fetch_id_base = oldest_pre_issue_id;
            decode_id_base = oldest_pre_issue_id;
        end else begin
            pc_id_base = early_branch_flush ? fetch_id : pc_id;
            fetch_id_base = fetch_id;
            decode_id_base = decode_id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_id <= '0;
            fetch_id <= '0;
            decode_id <= '0;
        end else begin
            // No strobe counts in the flush cycle
            pc_id <= pc_id_base + id_t'(pc_id_assigned & ~gc_fetch_flush);
            fetch_id <= fetch_id_base + id_t'(fetch_complete & ~gc_fetch_flush);
            decode_id <= decode_id_base + id_t'(decode_advance & ~gc_fetch_flush);
        end
    end

    //////////////////////////////////////////////////
    // Counts

    // Fetched but not decoded
    always_ff @(posedge clk) begin
        if (rst || gc_fetch_flush) begin
            fetched_count <= '0;
        end else begin
            fetched_count <= fetched_count + count_t'(fetch_complete)
                - count_t'(decode_advance);
        end
    end

    assign pre_issue_count_next = pre_issue_count + count_t'(pc_id_assigned)
        - count_t'(instruction_issued);
    assign post_issue_count_next = post_issue_count + count_t'(instruction_issued)
        - count_t'(retire_count);

    always_ff @(posedge clk) begin
        if (rst || gc_fetch_flush) begin
            pre_issue_count <= '0;
        end else begin
            pre_issue_count <= pre_issue_count_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            post_issue_count <= '0;
            inflight_count <= '0;
        end else begin
            post_issue_count <= post_issue_count_next;
            // Pre-issue IDs are dropped by a flush
            inflight_count <= (gc_fetch_flush ? '0 : pre_issue_count_next)
                + post_issue_count_next;
        end
    end

    // Top bit set only for a full pool
    assign pc_id_available = ~inflight_count[LOG2_MAX_IDS];
    assign decode_valid = |fetched_count;

    //////////////////////////////////////////////////
    // Assertions

    pc_id_assigned_when_available: assert property (
        @(posedge clk) disable iff (rst) pc_id_assigned |-> pc_id_available
    ) else $error("ID assigned with no ID available");

    decode_advance_when_valid: assert property (
        @(posedge clk) disable iff (rst) decode_advance |-> decode_valid
    ) else $error("Decode advanced with no valid instruction");

endmodule

`default_nettype wire

/* source/id_pkg.sv */
/*
 * Sizes of the ID pool and ports, and the packed types used
 * between fetch, decode, issue, writeback and retire
 */
`default_nettype none

package id_pkg;

    //////////////////////////////////////////////////
    // Sizes

    // ID pool
    localparam int MAX_IDS = 8;
    localparam int LOG2_MAX_IDS = 3;

    // Up to two instructions retire per cycle
    localparam int RETIRE_PORTS = 2;
    localparam int LOG2_RETIRE_PORTS = 1;

    // Group 0 completes in one cycle, group 1 is multicycle
    localparam int NUM_WB_GROUPS = 2;

    //////////////////////////////////////////////////
    // Types

    typedef logic [LOG2_MAX_IDS-1:0] id_t;
    // Wide enough to hold a full pool
    typedef logic [LOG2_MAX_IDS:0] count_t;
    // Address 0 means no destination
    typedef logic [5:0] phys_addr_t;
    // Retired instructions this cycle, 0 to RETIRE_PORTS
    typedef logic [LOG2_RETIRE_PORTS:0] retire_count_t;

    // Status bits captured at fetch
    typedef struct packed {
        logic valid_addr;
        logic access_fault;
    } fetch_metadata_t;

    // Per-ID fields read out of the tables for decode
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instruction;
        fetch_metadata_t fetch_metadata;
    } decode_fields_t;

    typedef struct packed {
        logic valid;
        id_t id;
        logic [31:0] pc;
        logic [31:0] instruction;
        fetch_metadata_t fetch_metadata;
    } decode_packet_t;

    typedef struct packed {
        logic stage_valid;
        id_t id;
        phys_addr_t phys_rd_addr;
        logic is_multicycle;
    } issue_packet_t;

    typedef struct packed {
        logic valid;
        id_t id;
        logic [31:0] data;
    } wb_packet_t;

    typedef struct packed {
        logic valid;
        id_t id;
        phys_addr_t phys_addr;
        logic [31:0] data;
    } commit_packet_t;

    typedef struct packed {
        logic valid;
        id_t phys_id;
        retire_count_t count;
    } retire_packet_t;

endpackage

`default_nettype wire
